// File: design/csr_scoreboard.sv
//################################################
// CSR scoreboard: serializes CSR accesses behind
// one outstanding CSR write
//################################################
`timescale 1ns/1ps

module csr_scoreboard (
    input  logic clk,
    input  logic rst_n,
    input  logic issue_i,
    input  logic csr_we_i,
    input  logic csr_re_i,
    input  logic csr_wb_valid_i,
    output logic csr_hazard_o
);

    logic csr_pending;

    // set has priority over a writeback in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_pending <= 1'b0;
        end else if (issue_i && csr_we_i) begin
            csr_pending <= 1'b1;
        end else if (csr_wb_valid_i) begin
            csr_pending <= 1'b0;
        end
    end

    // any csr access at the head waits for the pending write
    assign csr_hazard_o = csr_pending && (csr_we_i || csr_re_i);

endmodule

// File: design/dispatch_pkg.sv
//################################################
// Dispatch package: shared widths, RV32I major
// opcodes and the two-view instruction word
//################################################
package dispatch_pkg;

    // data and address widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // one instruction word, read as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } rv_inst_u;

endpackage

// File: design/dispatch_reserve_stack.sv
//################################################
// Dispatch reserve stack: fall-through FIFO that
// holds decoded instructions while issue stalls
//################################################
`timescale 1ns/1ps

module dispatch_reserve_stack
    import dispatch_pkg::*;
#(
    parameter int STACK_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push_req_i,
    input  logic                  fifo_stall_i,
    input  logic                  fifo_flush_i,
    output logic                  fifo_full_o,
    input  logic                  inst_valid_i,
    input  logic                  illegal_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  pred_branch_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  rd_we_i,
    input  logic                  rs1_re_i,
    input  logic                  rs2_re_i,
    input  logic                  csr_we_i,
    input  logic                  csr_re_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    output logic                  inst_valid_o,
    output logic                  illegal_o,
    output logic [XLEN-1:0]       inst_o,
    output logic [XLEN-1:0]       pc_o,
    output logic                  pred_branch_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  rd_we_o,
    output logic                  rs1_re_o,
    output logic                  rs2_re_o,
    output logic                  csr_we_o,
    output logic                  csr_re_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o
);

    localparam int PTR_W   = $clog2(STACK_DEPTH);
    localparam int ENTRY_W = 3 * XLEN + 3 * REG_ADDR_W + CSR_ADDR_W + 7;

    logic [PTR_W:0]       fifo_count;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [ENTRY_W-1:0]   fifo_mem [STACK_DEPTH];
    logic [ENTRY_W-1:0]   in_entry;
    logic [ENTRY_W-1:0]   head_entry;
    logic                 fifo_empty;
    logic                 fifo_full;
    logic                 push_en;
    logic                 pop_en;
    logic                 head_rd_we;

    assign fifo_empty  = (fifo_count == '0);
    assign fifo_full   = (fifo_count == (PTR_W + 1)'(STACK_DEPTH));
    assign fifo_full_o = fifo_full;

    // stalled input is kept, and once queued every valid input lines up behind
    assign push_en = inst_valid_i && (push_req_i || !fifo_empty) && !fifo_full;
    assign pop_en  = !fifo_empty && !fifo_stall_i;

    // stored entries are always valid, so the valid bit is not kept
    assign in_entry = {illegal_i, inst_i, pc_i, pred_branch_i, imm_i, rd_i, rs1_i, rs2_i,
                       rd_we_i, rs1_re_i, rs2_re_i, csr_we_i, csr_re_i, csr_addr_i};

    // fall through while empty
    assign head_entry = fifo_empty ? in_entry : fifo_mem[rd_ptr];

    assign {illegal_o, inst_o, pc_o, pred_branch_o, imm_o, rd_o, rs1_o, rs2_o,
            head_rd_we, rs1_re_o, rs2_re_o, csr_we_o, csr_re_o, csr_addr_o} = head_entry;

    // flush hides the head in its own cycle
    assign inst_valid_o = !fifo_flush_i && (fifo_empty ? inst_valid_i : 1'b1);
    assign rd_we_o      = !fifo_flush_i && head_rd_we;

    always_ff @(posedge clk) begin
        if (push_en) begin
            fifo_mem[wr_ptr] <= in_entry;
        end
    end

    // pointers wrap by themselves since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_count <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else if (fifo_flush_i) begin
            fifo_count <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            case ({push_en, pop_en})
                2'b10: begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    fifo_count <= fifo_count + 1'b1;
                end
                2'b01: begin
                    rd_ptr     <= rd_ptr + 1'b1;
                    fifo_count <= fifo_count - 1'b1;
                end
                2'b11: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    rd_ptr <= rd_ptr + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/dispatch_top.sv
//################################################
// Dispatch stage top: decoder, reserve stack,
// scoreboards and issue controller
//################################################
`timescale 1ns/1ps

module dispatch_top
    import dispatch_pkg::*;
#(
    parameter int STACK_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  pred_branch_i,
    input  logic                  flush_i,
    input  logic                  exec_ready_i,
    input  logic                  wb_valid_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic                  csr_wb_valid_i,
    output logic                  stack_full_o,
    output logic                  issue_valid_o,
    output logic [XLEN-1:0]       issue_pc_o,
    output logic [XLEN-1:0]       issue_inst_o,
    output logic [XLEN-1:0]       issue_imm_o,
    output logic [REG_ADDR_W-1:0] issue_rd_o,
    output logic                  issue_rd_we_o,
    output logic                  issue_illegal_o,
    output logic                  issue_pred_branch_o
);

    // decoder outputs
    logic                  dec_illegal;
    logic [XLEN-1:0]       dec_imm;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic                  dec_rd_we;
    logic                  dec_rs1_re;
    logic                  dec_rs2_re;
    logic                  dec_csr_we;
    logic                  dec_csr_re;
    logic [CSR_ADDR_W-1:0] dec_csr_addr;

    // stack head
    logic                  head_valid;
    logic [REG_ADDR_W-1:0] head_rs1;
    logic [REG_ADDR_W-1:0] head_rs2;
    logic                  head_rd_we;
    logic                  head_rs1_re;
    logic                  head_rs2_re;
    logic                  head_csr_we;
    logic                  head_csr_re;

    logic                  reg_hazard;
    logic                  csr_hazard;
    logic                  issue;
    logic                  stall;

    assign issue_valid_o = issue;
    assign issue_rd_we_o = issue && head_rd_we;

    inst_decoder u_decoder (
        .inst_i     (inst_i),
        .illegal_o  (dec_illegal),
        .imm_o      (dec_imm),
        .rd_o       (dec_rd),
        .rs1_o      (dec_rs1),
        .rs2_o      (dec_rs2),
        .rd_we_o    (dec_rd_we),
        .rs1_re_o   (dec_rs1_re),
        .rs2_re_o   (dec_rs2_re),
        .csr_we_o   (dec_csr_we),
        .csr_re_o   (dec_csr_re),
        .csr_addr_o (dec_csr_addr)
    );

    // csr address is carried along for the execute side only
    dispatch_reserve_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_stack (
        .clk           (clk),
        .rst_n         (rst_n),
        .push_req_i    (stall),
        .fifo_stall_i  (stall),
        .fifo_flush_i  (flush_i),
        .fifo_full_o   (stack_full_o),
        .inst_valid_i  (inst_valid_i),
        .illegal_i     (dec_illegal),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .pred_branch_i (pred_branch_i),
        .imm_i         (dec_imm),
        .rd_i          (dec_rd),
        .rs1_i         (dec_rs1),
        .rs2_i         (dec_rs2),
        .rd_we_i       (dec_rd_we),
        .rs1_re_i      (dec_rs1_re),
        .rs2_re_i      (dec_rs2_re),
        .csr_we_i      (dec_csr_we),
        .csr_re_i      (dec_csr_re),
        .csr_addr_i    (dec_csr_addr),
        .inst_valid_o  (head_valid),
        .illegal_o     (issue_illegal_o),
        .inst_o        (issue_inst_o),
        .pc_o          (issue_pc_o),
        .pred_branch_o (issue_pred_branch_o),
        .imm_o         (issue_imm_o),
        .rd_o          (issue_rd_o),
        .rs1_o         (head_rs1),
        .rs2_o         (head_rs2),
        .rd_we_o       (head_rd_we),
        .rs1_re_o      (head_rs1_re),
        .rs2_re_o      (head_rs2_re),
        .csr_we_o      (head_csr_we),
        .csr_re_o      (head_csr_re),
        .csr_addr_o    ()
    );

    reg_scoreboard u_reg_sb (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_i      (issue),
        .rs1_i        (head_rs1),
        .rs2_i        (head_rs2),
        .rd_i         (issue_rd_o),
        .rs1_re_i     (head_rs1_re),
        .rs2_re_i     (head_rs2_re),
        .rd_we_i      (head_rd_we),
        .wb_valid_i   (wb_valid_i),
        .wb_rd_i      (wb_rd_i),
        .reg_hazard_o (reg_hazard)
    );

    csr_scoreboard u_csr_sb (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_i        (issue),
        .csr_we_i       (head_csr_we),
        .csr_re_i       (head_csr_re),
        .csr_wb_valid_i (csr_wb_valid_i),
        .csr_hazard_o   (csr_hazard)
    );

    issue_ctrl u_issue (
        .head_valid_i (head_valid),
        .reg_hazard_i (reg_hazard),
        .csr_hazard_i (csr_hazard),
        .exec_ready_i (exec_ready_i),
        .issue_o      (issue),
        .stall_o      (stall)
    );

endmodule

// File: design/inst_decoder.sv
//################################################
// RV32I instruction decoder: register, CSR and
// immediate fields plus an illegal-opcode flag
//################################################
`timescale 1ns/1ps

module inst_decoder
    import dispatch_pkg::*;
(
    input  rv_inst_u              inst_i,
    output logic                  illegal_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  rd_we_o,
    output logic                  rs1_re_o,
    output logic                  rs2_re_o,
    output logic                  csr_we_o,
    output logic                  csr_re_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o
);

    logic [XLEN-1:0] word;
    logic            rd_write;

    // raw bits for the S, B, U and J immediate layouts
    assign word = inst_i;

    assign rd_o       = inst_i.i.rd;
    assign rs1_o      = inst_i.i.rs1;
    assign rs2_o      = inst_i.r.rs2;
    assign csr_addr_o = inst_i.i.imm12;

    // x0 is never a write target
    assign rd_we_o = rd_write && (inst_i.i.rd != '0);

    always_comb begin
        illegal_o = 1'b0;
        imm_o     = '0;
        rd_write  = 1'b0;
        rs1_re_o  = 1'b0;
        rs2_re_o  = 1'b0;
        csr_we_o  = 1'b0;
        csr_re_o  = 1'b0;
        case (inst_i.i.opcode)
            OPC_OP: begin
                rd_write = 1'b1;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                imm_o    = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
                rd_write = 1'b1;
                rs1_re_o = 1'b1;
            end
            OPC_STORE: begin
                imm_o    = {{(XLEN-12){word[31]}}, word[31:25], word[11:7]};
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o    = {{(XLEN-13){word[31]}}, word[31], word[7], word[30:25],
                            word[11:8], 1'b0};
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
            end
            OPC_JAL: begin
                imm_o    = {{(XLEN-21){word[31]}}, word[31], word[19:12], word[20],
                            word[30:21], 1'b0};
                rd_write = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                imm_o    = {word[31:12], 12'b0};
                rd_write = 1'b1;
            end
            OPC_SYSTEM: begin
                // funct3 zero is ecall/ebreak, no operands
                if (inst_i.i.funct3 != 3'b000) begin
                    imm_o    = {{(XLEN-REG_ADDR_W){1'b0}}, inst_i.i.rs1};
                    rd_write = 1'b1;
                    rs1_re_o = !inst_i.i.funct3[2];
                    // csrrw with rd=x0 skips the read, set/clear with rs1=x0 skip the write
                    csr_we_o = (inst_i.i.funct3[1:0] == 2'b01) || (inst_i.i.rs1 != '0);
                    csr_re_o = (inst_i.i.funct3[1:0] != 2'b01) || (inst_i.i.rd != '0);
                end
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// File: design/issue_ctrl.sv
//################################################
// Issue controller: merges hazards with execute
// ready into issue and stall
//################################################
`timescale 1ns/1ps

module issue_ctrl (
    input  logic head_valid_i,
    input  logic reg_hazard_i,
    input  logic csr_hazard_i,
    input  logic exec_ready_i,
    output logic issue_o,
    output logic stall_o
);

    logic hazard_free;

    assign hazard_free = !reg_hazard_i && !csr_hazard_i;

    // head goes out only when nothing blocks it
    assign issue_o = head_valid_i && hazard_free && exec_ready_i;

    // a valid head that stays put stalls the stack
    assign stall_o = head_valid_i && !issue_o;

endmodule

// File: design/reg_scoreboard.sv
//################################################
// Register scoreboard: one pending-write bit per
// general register, RAW and WAW hazard detection
//################################################
`timescale 1ns/1ps

module reg_scoreboard
    import dispatch_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  rs1_re_i,
    input  logic                  rs2_re_i,
    input  logic                  rd_we_i,
    input  logic                  wb_valid_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    output logic                  reg_hazard_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] pending_nxt;

    always_comb begin
        pending_nxt = pending;
        if (wb_valid_i) begin
            pending_nxt[wb_rd_i] = 1'b0;
        end
        // a new write overrides a writeback to the same register
        if (issue_i && rd_we_i) begin
            pending_nxt[rd_i] = 1'b1;
        end
        pending_nxt[0] = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

    // sources give RAW, destination gives WAW
    assign reg_hazard_o = (rs1_re_i && pending[rs1_i]) ||
                          (rs2_re_i && pending[rs2_i]) ||
                          (rd_we_i  && pending[rd_i]);

endmodule

// File: dispatch_unit.f
design/dispatch_pkg.sv
design/inst_decoder.sv
design/dispatch_reserve_stack.sv
design/reg_scoreboard.sv
design/csr_scoreboard.sv
design/issue_ctrl.sv
design/dispatch_top.sv
tests/tb_clk_gen.sv
tests/dispatch_tb.sv

// File: tests/dispatch_tb.sv
//################################################
// Dispatch stage testbench: per-cycle table of
// stimulus and expected issue results
//################################################
`timescale 1ns/1ps

module dispatch_tb
    import dispatch_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_ROWS     = 64;
    localparam int WD_MARGIN    = 20;
    localparam int N_FILL       = 6;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic                  pred_branch;
    logic                  flush;
    logic                  exec_ready;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  csr_wb_valid;
    logic                  stack_full_o;
    logic                  issue_valid_o;
    logic [XLEN-1:0]       issue_pc_o;
    logic [XLEN-1:0]       issue_inst_o;
    logic [XLEN-1:0]       issue_imm_o;
    logic [REG_ADDR_W-1:0] issue_rd_o;
    logic                  issue_rd_we_o;
    logic                  issue_illegal_o;
    logic                  issue_pred_branch_o;

    // stimulus columns
    logic                  t_valid [MAX_ROWS];
    logic [XLEN-1:0]       t_inst [MAX_ROWS];
    logic [XLEN-1:0]       t_pc [MAX_ROWS];
    logic                  t_pred [MAX_ROWS];
    logic                  t_ready [MAX_ROWS];
    logic                  t_flush [MAX_ROWS];
    logic                  t_wb [MAX_ROWS];
    logic [REG_ADDR_W-1:0] t_wb_rd [MAX_ROWS];
    logic                  t_csr_wb [MAX_ROWS];
    // expected columns
    logic                  e_issue [MAX_ROWS];
    logic [XLEN-1:0]       e_pc [MAX_ROWS];
    logic [XLEN-1:0]       e_inst [MAX_ROWS];
    logic                  e_pred [MAX_ROWS];
    logic [XLEN-1:0]       e_imm [MAX_ROWS];
    logic [REG_ADDR_W-1:0] e_rd [MAX_ROWS];
    logic                  e_rd_we [MAX_ROWS];
    logic                  e_illegal [MAX_ROWS];
    logic                  e_full [MAX_ROWS];

    integer n_rows   = 0;
    integer cur_row  = 0;
    integer n_checks = 0;
    integer n_errors = 0;
    integer seed     = 79533;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dispatch_top #(
        .STACK_DEPTH (4)
    ) UUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .inst_valid_i        (inst_valid),
        .inst_i              (inst),
        .pc_i                (pc),
        .pred_branch_i       (pred_branch),
        .flush_i             (flush),
        .exec_ready_i        (exec_ready),
        .wb_valid_i          (wb_valid),
        .wb_rd_i             (wb_rd),
        .csr_wb_valid_i      (csr_wb_valid),
        .stack_full_o        (stack_full_o),
        .issue_valid_o       (issue_valid_o),
        .issue_pc_o          (issue_pc_o),
        .issue_inst_o        (issue_inst_o),
        .issue_imm_o         (issue_imm_o),
        .issue_rd_o          (issue_rd_o),
        .issue_rd_we_o       (issue_rd_we_o),
        .issue_illegal_o     (issue_illegal_o),
        .issue_pred_branch_o (issue_pred_branch_o)
    );

    // instruction encoders per the RV32I formats
    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm12,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_i = {imm12, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        enc_r = {7'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] val);
        sext12 = {{20{val[11]}}, val};
    endfunction

    task automatic new_row(input logic valid, input logic [31:0] word,
                           input logic [31:0] addr, input logic ready);
        t_valid[n_rows]   = valid;
        t_inst[n_rows]    = word;
        t_pc[n_rows]      = addr;
        t_pred[n_rows]    = 1'b0;
        t_ready[n_rows]   = ready;
        t_flush[n_rows]   = 1'b0;
        t_wb[n_rows]      = 1'b0;
        t_wb_rd[n_rows]   = '0;
        t_csr_wb[n_rows]  = 1'b0;
        e_issue[n_rows]   = 1'b0;
        e_pc[n_rows]      = '0;
        e_inst[n_rows]    = '0;
        e_pred[n_rows]    = 1'b0;
        e_imm[n_rows]     = '0;
        e_rd[n_rows]      = '0;
        e_rd_we[n_rows]   = 1'b0;
        e_illegal[n_rows] = 1'b0;
        e_full[n_rows]    = 1'b0;
        n_rows = n_rows + 1;
    endtask

    task automatic writeback(input logic [4:0] rd);
        t_wb[n_rows-1]    = 1'b1;
        t_wb_rd[n_rows-1] = rd;
    endtask

    task automatic expect_issue(input logic [31:0] addr, input logic [31:0] imm,
                                input logic [4:0] rd, input logic rd_we, input logic illegal);
        integer j;
        e_issue[n_rows-1]   = 1'b1;
        e_pc[n_rows-1]      = addr;
        e_imm[n_rows-1]     = imm;
        e_rd[n_rows-1]      = rd;
        e_rd_we[n_rows-1]   = rd_we;
        e_illegal[n_rows-1] = illegal;
        // every offered pc is unique, its row gives word and prediction flag
        for (j = 0; j < n_rows; j = j + 1) begin
            if (t_valid[j] && (t_pc[j] == addr)) begin
                e_inst[n_rows-1] = t_inst[j];
                e_pred[n_rows-1] = t_pred[j];
            end
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  prev_rd;
        integer      k;
        addr    = 32'h100;
        prev_rd = '0;
        // idle row right after reset
        new_row(1'b0, '0, '0, 1'b1);
        // back-to-back addi with random rd in x8..x23, never twice in a row
        for (k = 0; k < N_FILL; k = k + 1) begin
            rnd = $random(seed);
            rd  = 5'd8 + {1'b0, rnd[3:0]};
            if (rd == prev_rd) begin
                rd = (rd == 5'd23) ? 5'd8 : rd + 5'd1;
            end
            imm = rnd[19:8];
            new_row(1'b1, enc_i(OPC_OP_IMM, imm, 5'd0, 3'b000, rd), addr, 1'b1);
            t_pred[n_rows-1] = rnd[20];
            if (k > 0) begin
                writeback(prev_rd);
            end
            expect_issue(addr, sext12(imm), rd, 1'b1, 1'b0);
            addr    = addr + 4;
            prev_rd = rd;
        end
        new_row(1'b1, {20'habcde, 5'd7, OPC_LUI}, addr, 1'b1);
        t_pred[n_rows-1] = 1'b1;
        writeback(prev_rd);
        expect_issue(addr, 32'habcde000, 5'd7, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd7);
        // RAW on x1 holds the add until the cycle after writeback
        new_row(1'b1, enc_i(OPC_OP_IMM, 12'd5, 5'd0, 3'b000, 5'd1), addr, 1'b1);
        expect_issue(addr, 32'd5, 5'd1, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b1, enc_r(5'd0, 5'd1, 3'b000, 5'd2), addr, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd1);
        new_row(1'b0, '0, '0, 1'b1);
        expect_issue(addr, 32'd0, 5'd2, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd2);
        // execute not ready, four instructions queue up
        for (k = 0; k < 4; k = k + 1) begin
            new_row(1'b1, enc_i(OPC_OP_IMM, 12'h11 * (k + 1), 5'd0, 3'b000, 5'd3 + k),
                    addr + 4 * k, 1'b0);
            t_pred[n_rows-1] = k[0];
        end
        new_row(1'b0, '0, '0, 1'b0);
        e_full[n_rows-1] = 1'b1;
        for (k = 0; k < 4; k = k + 1) begin
            new_row(1'b0, '0, '0, 1'b1);
            if (k == 0) begin
                e_full[n_rows-1] = 1'b1;
            end else begin
                writeback(5'd3 + k - 1);
            end
            expect_issue(addr + 4 * k, 32'h11 * (k + 1), 5'd3 + k, 1'b1, 1'b0);
        end
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd6);
        addr = addr + 16;
        // csrrw mstatus then csrrs, which waits for the csr writeback
        new_row(1'b1, enc_i(OPC_SYSTEM, 12'h300, 5'd3, 3'b001, 5'd1), addr, 1'b1);
        // csr ops carry the rs1 field as zimm
        expect_issue(addr, 32'd3, 5'd1, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b1, enc_i(OPC_SYSTEM, 12'h300, 5'd0, 3'b010, 5'd2), addr, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
        t_csr_wb[n_rows-1] = 1'b1;
        writeback(5'd1);
        new_row(1'b0, '0, '0, 1'b1);
        expect_issue(addr, 32'd0, 5'd2, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd2);
        // two queued instructions dropped by flush
        new_row(1'b1, enc_i(OPC_OP_IMM, 12'd1, 5'd0, 3'b000, 5'd3), addr, 1'b0);
        new_row(1'b1, enc_i(OPC_OP_IMM, 12'd2, 5'd0, 3'b000, 5'd4), addr + 4, 1'b0);
        new_row(1'b0, '0, '0, 1'b1);
        t_flush[n_rows-1] = 1'b1;
        new_row(1'b0, '0, '0, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
        addr = addr + 8;
        new_row(1'b1, enc_i(OPC_OP_IMM, 12'h55, 5'd0, 3'b000, 5'd5), addr, 1'b1);
        expect_issue(addr, 32'h55, 5'd5, 1'b1, 1'b0);
        addr = addr + 4;
        new_row(1'b0, '0, '0, 1'b1);
        writeback(5'd5);
        // reserved opcode 1111111 goes out flagged, without a register write
        new_row(1'b1, enc_i(7'b1111111, 12'd0, 5'd0, 3'b000, 5'd9), addr, 1'b1);
        expect_issue(addr, 32'd0, 5'd9, 1'b0, 1'b1);
        new_row(1'b0, '0, '0, 1'b1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks = n_checks + 1;
        if (actual !== expected) begin
            n_errors = n_errors + 1;
            $display("[ERROR] row %0d %s: got %h, expected %h", cur_row, name, actual,
                     expected);
        end
    endtask

    initial begin
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        pred_branch  = 1'b0;
        flush        = 1'b0;
        exec_ready   = 1'b1;
        wb_valid     = 1'b0;
        wb_rd        = '0;
        csr_wb_valid = 1'b0;
        build_table();
        wait (rst_n === 1'b1);
        for (int r = 0; r < n_rows; r = r + 1) begin
            @(posedge clk);
            inst_valid   <= t_valid[r];
            inst         <= t_inst[r];
            pc           <= t_pc[r];
            pred_branch  <= t_pred[r];
            exec_ready   <= t_ready[r];
            flush        <= t_flush[r];
            wb_valid     <= t_wb[r];
            wb_rd        <= t_wb_rd[r];
            csr_wb_valid <= t_csr_wb[r];
            @(negedge clk);
            cur_row = r;
            check("issue_valid_o", issue_valid_o, e_issue[r]);
            check("issue_rd_we_o", issue_rd_we_o, e_rd_we[r]);
            check("stack_full_o", stack_full_o, e_full[r]);
            if (e_issue[r]) begin
                check("issue_pc_o", issue_pc_o, e_pc[r]);
                check("issue_inst_o", issue_inst_o, e_inst[r]);
                check("issue_pred_branch_o", issue_pred_branch_o, e_pred[r]);
                check("issue_imm_o", issue_imm_o, e_imm[r]);
                check("issue_rd_o", issue_rd_o, e_rd[r]);
                check("issue_illegal_o", issue_illegal_o, e_illegal[r]);
            end
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // run length follows the table size
    initial begin
        wait (n_rows > 0);
        #((RESET_CYCLES + n_rows + WD_MARGIN) * CLK_PERIOD);
        $display("timeout: the stimulus table did not complete in time");
        $display("Something failed");
        $finish;
    end

endmodule

// File: tests/tb_clk_gen.sv
//################################################
// Testbench clock and reset source
//################################################
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops at time zero and lifts on an edge after the hold
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
